/* Bender.yml */
package:
  name: mem_stage

sources:
  - files:
      - hw/mem_stage_pkg.sv
      - hw/ex_mem_reg.sv
      - hw/lsu.sv
      - hw/data_ram.sv
      - hw/mem_wb_reg.sv
      - hw/mem_stage_top.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/mem_stage_props.sv
      - testbench/mem_stage_tb.sv

/* flist.f */
hw/mem_stage_pkg.sv
hw/ex_mem_reg.sv
hw/lsu.sv
hw/data_ram.sv
hw/mem_wb_reg.sv
hw/mem_stage_top.sv
testbench/tb_clk_gen.sv
testbench/mem_stage_props.sv
testbench/mem_stage_tb.sv

/* hw/data_ram.sv */
`timescale 1ns/1ps

module data_ram
    import mem_stage_pkg::*;
(
    input  logic                  clk,
    input  logic                  data_ram_en,
    input  logic [BYTE_LANES-1:0] data_ram_wen,
    input  logic [DATA_W-1:0]     data_ram_addr,
    input  logic [DATA_W-1:0]     data_ram_wdata,
    output logic [DATA_W-1:0]     data_ram_rdata
);

    logic [DATA_W-1:0]         mem [RAM_DEPTH];
    logic [RAM_DEPTH_LOG2-1:0] word_addr;

    // upper address bits are dropped, so the space wraps.
    assign word_addr = data_ram_addr[RAM_DEPTH_LOG2+1:2];

    always_ff @(posedge clk) begin
        if (data_ram_en) begin
            data_ram_rdata <= mem[word_addr];             // read-first.
            for (int i = 0; i < BYTE_LANES; i++) begin
                if (data_ram_wen[i]) begin
                    mem[word_addr][i*BYTE_W +: BYTE_W] <= data_ram_wdata[i*BYTE_W +: BYTE_W];
                end
            end
        end
    end

endmodule

/* hw/ex_mem_reg.sv */
`timescale 1ns/1ps

module ex_mem_reg
    import mem_stage_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ex_valid,
    input  logic [DATA_W-1:0]     ex_alu_res,
    input  ls_sel_e               ex_ls_sel,
    input  logic                  ex_w_reg_ena,
    input  logic [REG_ADDR_W-1:0] ex_w_reg_dst,
    input  wb_sel_e               ex_wb_sel,
    input  exc_e                  ex_exc,
    output logic                  mem_valid,
    output logic [DATA_W-1:0]     mem_alu_res,
    output ls_sel_e               mem_ls_sel,
    output logic                  mem_w_reg_ena,
    output logic [REG_ADDR_W-1:0] mem_w_reg_dst,
    output wb_sel_e               mem_wb_sel,
    output exc_e                  mem_exc
);

    logic w_reg_ena_next;

    // a faulting or bubble instruction never reaches the register file.
    assign w_reg_ena_next = ex_valid & ex_w_reg_ena & (ex_exc == EXC_NONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid     <= 1'b0;
            mem_ls_sel    <= LS_NONE;
            mem_w_reg_ena <= 1'b0;
            mem_wb_sel    <= WB_ALU;
            mem_exc       <= EXC_NONE;
        end else begin
            mem_valid     <= ex_valid;
            mem_ls_sel    <= ex_valid ? ex_ls_sel : LS_NONE;  // bubbles carry no load.
            mem_w_reg_ena <= w_reg_ena_next;
            mem_wb_sel    <= ex_wb_sel;
            mem_exc       <= ex_exc;
        end
    end

    always_ff @(posedge clk) begin
        mem_alu_res   <= ex_alu_res;
        mem_w_reg_dst <= ex_w_reg_dst;
    end

endmodule

/* hw/lsu.sv */
`timescale 1ns/1ps

module lsu
    import mem_stage_pkg::*;
(
    input  logic                  ex_valid,
    input  logic [DATA_W-1:0]     ex_alu_res,
    input  logic [DATA_W-1:0]     ex_rt_data,
    input  ls_sel_e               ex_ls_sel,
    input  logic [DATA_W-1:0]     mem_alu_res,
    input  ls_sel_e               mem_ls_sel,
    input  logic [DATA_W-1:0]     data_ram_rdata,
    output logic                  data_ram_en,
    output logic [BYTE_LANES-1:0] data_ram_wen,
    output logic [DATA_W-1:0]     data_ram_addr,
    output logic [DATA_W-1:0]     data_ram_wdata,
    output exc_e                  ex_exc,
    output logic [DATA_W-1:0]     mem_r_data
);

    logic                  ex_is_load;
    logic                  ex_is_store;
    logic                  ex_misaligned;
    logic                  ex_access_ok;
    logic [1:0]            ex_off;
    logic [1:0]            mem_off;
    logic [BYTE_LANES-1:0] lane_mask;
    logic [DATA_W-1:0]     rdata_shifted;

    assign ex_off      = ex_alu_res[1:0];
    assign ex_is_load  = is_load(ex_ls_sel);
    assign ex_is_store = is_store(ex_ls_sel);

    always_comb begin
        case (ex_ls_sel)
            LS_LH, LS_LHU, LS_SH: ex_misaligned = ex_off[0];
            LS_LW, LS_SW:         ex_misaligned = |ex_off;
            default:              ex_misaligned = 1'b0;
        endcase
    end

    always_comb begin
        if (!ex_valid || !ex_misaligned)
            ex_exc = EXC_NONE;
        else if (ex_is_store)
            ex_exc = EXC_ADES;
        else
            ex_exc = EXC_ADEL;
    end

    assign ex_access_ok = ex_valid & ~ex_misaligned;

    // ex side, RAM request.
    always_comb begin
        case (ex_ls_sel)
            LS_SB:   lane_mask = BYTE_LANES'(1);
            LS_SH:   lane_mask = BYTE_LANES'(3);
            LS_SW:   lane_mask = '1;
            default: lane_mask = '0;
        endcase
    end

    assign data_ram_en   = ex_access_ok & (ex_is_load | ex_is_store);
    assign data_ram_wen  = ex_access_ok ? (lane_mask << ex_off) : '0;  // little-endian lanes.
    assign data_ram_addr = ex_alu_res;

    always_comb begin
        case (ex_ls_sel)
            LS_SB:   data_ram_wdata = {BYTE_LANES{ex_rt_data[BYTE_W-1:0]}};
            LS_SH:   data_ram_wdata = {(BYTE_LANES / 2){ex_rt_data[HALF_W-1:0]}};
            default: data_ram_wdata = ex_rt_data;
        endcase
    end

    // mem side, load extraction.
    assign mem_off       = mem_alu_res[1:0];
    assign rdata_shifted = data_ram_rdata >> {mem_off, 3'b000};

    always_comb begin
        case (mem_ls_sel)
            LS_LB:
                mem_r_data = {{(DATA_W - BYTE_W){rdata_shifted[BYTE_W-1]}},
                              rdata_shifted[BYTE_W-1:0]};
            LS_LBU:
                mem_r_data = {{(DATA_W - BYTE_W){1'b0}}, rdata_shifted[BYTE_W-1:0]};
            LS_LH:
                mem_r_data = {{(DATA_W - HALF_W){rdata_shifted[HALF_W-1]}},
                              rdata_shifted[HALF_W-1:0]};
            LS_LHU:
                mem_r_data = {{(DATA_W - HALF_W){1'b0}}, rdata_shifted[HALF_W-1:0]};
            LS_LW:
                mem_r_data = data_ram_rdata;
            default:
                mem_r_data = '0;
        endcase
    end

endmodule

/* hw/mem_stage_pkg.sv */
package mem_stage_pkg;

    localparam int DATA_W         = 32;
    localparam int REG_ADDR_W     = 5;
    localparam int RAM_DEPTH_LOG2 = 8;                    // word-address bits of the data RAM.
    localparam int RAM_DEPTH      = 1 << RAM_DEPTH_LOG2;
    localparam int BYTE_W         = 8;
    localparam int HALF_W         = 16;
    localparam int BYTE_LANES     = DATA_W / BYTE_W;

    typedef enum logic [3:0] {
        LS_NONE = 4'd0,
        LS_LB   = 4'd1,
        LS_LBU  = 4'd2,
        LS_LH   = 4'd3,
        LS_LHU  = 4'd4,
        LS_LW   = 4'd5,
        LS_SB   = 4'd6,
        LS_SH   = 4'd7,
        LS_SW   = 4'd8
    } ls_sel_e;

    typedef enum logic {
        WB_ALU = 1'b0,
        WB_MEM = 1'b1
    } wb_sel_e;

    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_ADEL = 2'd1,                                  // misaligned load.
        EXC_ADES = 2'd2                                   // misaligned store.
    } exc_e;

    function automatic logic is_load(ls_sel_e sel);
        return sel inside {LS_LB, LS_LBU, LS_LH, LS_LHU, LS_LW};
    endfunction

    function automatic logic is_store(ls_sel_e sel);
        return sel inside {LS_SB, LS_SH, LS_SW};
    endfunction

endpackage

/* hw/mem_stage_top.sv */
`timescale 1ns/1ps

module mem_stage_top
    import mem_stage_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ex_valid,
    input  logic [DATA_W-1:0]     ex_alu_res,
    input  logic [DATA_W-1:0]     ex_rt_data,
    input  ls_sel_e               ex_ls_sel,
    input  logic                  ex_w_reg_ena,
    input  logic [REG_ADDR_W-1:0] ex_w_reg_dst,
    input  wb_sel_e               ex_wb_sel,
    output logic                  wb_valid,
    output logic                  wb_w_reg_ena,
    output logic [REG_ADDR_W-1:0] wb_w_reg_dst,
    output logic [DATA_W-1:0]     wb_data,
    output exc_e                  wb_exc
);

    logic                  data_ram_en;
    logic [BYTE_LANES-1:0] data_ram_wen;
    logic [DATA_W-1:0]     data_ram_addr;
    logic [DATA_W-1:0]     data_ram_wdata;
    logic [DATA_W-1:0]     data_ram_rdata;
    exc_e                  ex_exc;

    logic                  mem_valid;
    logic [DATA_W-1:0]     mem_alu_res;
    ls_sel_e               mem_ls_sel;
    logic                  mem_w_reg_ena;
    logic [REG_ADDR_W-1:0] mem_w_reg_dst;
    wb_sel_e               mem_wb_sel;
    exc_e                  mem_exc;
    logic [DATA_W-1:0]     mem_r_data;

    lsu lsu_inst (
        .ex_valid       (ex_valid),
        .ex_alu_res     (ex_alu_res),
        .ex_rt_data     (ex_rt_data),
        .ex_ls_sel      (ex_ls_sel),
        .mem_alu_res    (mem_alu_res),
        .mem_ls_sel     (mem_ls_sel),
        .data_ram_rdata (data_ram_rdata),
        .data_ram_en    (data_ram_en),
        .data_ram_wen   (data_ram_wen),
        .data_ram_addr  (data_ram_addr),
        .data_ram_wdata (data_ram_wdata),
        .ex_exc         (ex_exc),
        .mem_r_data     (mem_r_data)
    );

    ex_mem_reg ex_mem_reg_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_valid      (ex_valid),
        .ex_alu_res    (ex_alu_res),
        .ex_ls_sel     (ex_ls_sel),
        .ex_w_reg_ena  (ex_w_reg_ena),
        .ex_w_reg_dst  (ex_w_reg_dst),
        .ex_wb_sel     (ex_wb_sel),
        .ex_exc        (ex_exc),
        .mem_valid     (mem_valid),
        .mem_alu_res   (mem_alu_res),
        .mem_ls_sel    (mem_ls_sel),
        .mem_w_reg_ena (mem_w_reg_ena),
        .mem_w_reg_dst (mem_w_reg_dst),
        .mem_wb_sel    (mem_wb_sel),
        .mem_exc       (mem_exc)
    );

    data_ram data_ram_inst (
        .clk            (clk),
        .data_ram_en    (data_ram_en),
        .data_ram_wen   (data_ram_wen),
        .data_ram_addr  (data_ram_addr),
        .data_ram_wdata (data_ram_wdata),
        .data_ram_rdata (data_ram_rdata)
    );

    mem_wb_reg mem_wb_reg_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_valid     (mem_valid),
        .mem_alu_res   (mem_alu_res),
        .mem_r_data    (mem_r_data),
        .mem_w_reg_ena (mem_w_reg_ena),
        .mem_w_reg_dst (mem_w_reg_dst),
        .mem_wb_sel    (mem_wb_sel),
        .mem_exc       (mem_exc),
        .wb_valid      (wb_valid),
        .wb_w_reg_ena  (wb_w_reg_ena),
        .wb_w_reg_dst  (wb_w_reg_dst),
        .wb_data       (wb_data),
        .wb_exc        (wb_exc)
    );

endmodule

/* hw/mem_wb_reg.sv */
`timescale 1ns/1ps

module mem_wb_reg
    import mem_stage_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mem_valid,
    input  logic [DATA_W-1:0]     mem_alu_res,
    input  logic [DATA_W-1:0]     mem_r_data,
    input  logic                  mem_w_reg_ena,
    input  logic [REG_ADDR_W-1:0] mem_w_reg_dst,
    input  wb_sel_e               mem_wb_sel,
    input  exc_e                  mem_exc,
    output logic                  wb_valid,
    output logic                  wb_w_reg_ena,
    output logic [REG_ADDR_W-1:0] wb_w_reg_dst,
    output logic [DATA_W-1:0]     wb_data,
    output exc_e                  wb_exc
);

    logic [DATA_W-1:0] wb_data_next;

    assign wb_data_next = (mem_wb_sel == WB_MEM) ? mem_r_data : mem_alu_res;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid     <= 1'b0;
            wb_w_reg_ena <= 1'b0;
            wb_exc       <= EXC_NONE;
        end else begin
            wb_valid     <= mem_valid;
            wb_w_reg_ena <= mem_valid & mem_w_reg_ena;
            wb_exc       <= mem_valid ? mem_exc : EXC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        wb_data      <= wb_data_next;
        wb_w_reg_dst <= mem_w_reg_dst;
    end

endmodule

/* testbench/mem_stage_props.sv */
`timescale 1ns/1ps

module mem_stage_props
    import mem_stage_pkg::*;
(
    input logic                  clk,
    input logic                  rst_n,
    input logic                  ex_valid,
    input logic                  data_ram_en,
    input logic [BYTE_LANES-1:0] data_ram_wen,
    input logic                  wb_valid,
    input logic                  wb_w_reg_ena,
    input exc_e                  wb_exc
);

    logic ex_seen;
    logic ex_seen_d;
    int   fail_count = 0;                                 // read by the testbench at the end.

    // first instruction reaches wb two edges after it is taken.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_seen   <= 1'b0;
            ex_seen_d <= 1'b0;
        end else begin
            ex_seen   <= ex_seen | ex_valid;
            ex_seen_d <= ex_seen;
        end
    end

    wen_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
        (|data_ram_wen) |-> data_ram_en)
        else begin
            $error("byte write enable seen without RAM enable");
            fail_count++;
        end

    ena_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        wb_w_reg_ena |-> wb_valid)
        else begin
            $error("register write enable seen without wb_valid");
            fail_count++;
        end

    exc_blocks_write: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_exc != EXC_NONE) |-> !wb_w_reg_ena)
        else begin
            $error("faulting instruction writes the register file");
            fail_count++;
        end

    no_early_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !ex_seen_d |-> !wb_valid)
        else begin
            $error("wb_valid high before any instruction could arrive");
            fail_count++;
        end

endmodule

bind mem_stage_top mem_stage_props mem_stage_props_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_valid     (ex_valid),
    .data_ram_en  (data_ram_en),
    .data_ram_wen (data_ram_wen),
    .wb_valid     (wb_valid),
    .wb_w_reg_ena (wb_w_reg_ena),
    .wb_exc       (wb_exc)
);

/* testbench/mem_stage_tb.sv */
`timescale 1ns/1ps

module mem_stage_tb
    import mem_stage_pkg::*;
();

    localparam int MAX_ROWS  = 128;
    localparam int N_TESTS   = 6;
    localparam int REF_BYTES = RAM_DEPTH * BYTE_LANES;

    typedef struct {
        logic [DATA_W-1:0]     data;
        logic                  chk_data;
        exc_e                  exc;
        logic                  ena;
        logic [REG_ADDR_W-1:0] dst;
        int                    test;
    } exp_t;

    logic clk, rst_n, ex_valid, ex_w_reg_ena;
    logic [DATA_W-1:0] ex_alu_res, ex_rt_data, wb_data;
    ls_sel_e ex_ls_sel;
    wb_sel_e ex_wb_sel;
    logic [REG_ADDR_W-1:0] ex_w_reg_dst, wb_w_reg_dst;
    logic wb_valid, wb_w_reg_ena;
    exc_e wb_exc;

    ls_sel_e               row_sel [MAX_ROWS];
    logic [DATA_W-1:0]     row_addr [MAX_ROWS];
    logic [DATA_W-1:0]     row_rt [MAX_ROWS];
    wb_sel_e               row_wbs [MAX_ROWS];
    logic                  row_ena [MAX_ROWS];
    logic [REG_ADDR_W-1:0] row_dst [MAX_ROWS];
    int                    row_test [MAX_ROWS];
    int n_rows, errors, checks, tests_failed, cur_test;
    int rows_left [N_TESTS];
    int test_err [N_TESTS];
    string test_name [N_TESTS] = '{"reset", "word_path", "byte_half_store",
                                   "load_extension", "address_error", "alu_writeback"};
    logic [BYTE_W-1:0] ref_mem [REF_BYTES];               // byte-wide reference memory.
    exp_t exp_q [$];
    logic timed_out;

    tb_clk_gen tb_clk_gen_inst (.clk(clk), .rst_n(rst_n));

    mem_stage_top mem_stage_top_inst (
        .clk(clk), .rst_n(rst_n), .ex_valid(ex_valid), .ex_alu_res(ex_alu_res),
        .ex_rt_data(ex_rt_data), .ex_ls_sel(ex_ls_sel), .ex_w_reg_ena(ex_w_reg_ena),
        .ex_w_reg_dst(ex_w_reg_dst), .ex_wb_sel(ex_wb_sel), .wb_valid(wb_valid),
        .wb_w_reg_ena(wb_w_reg_ena), .wb_w_reg_dst(wb_w_reg_dst), .wb_data(wb_data),
        .wb_exc(wb_exc)
    );

    function automatic logic misaligned(ls_sel_e sel, logic [DATA_W-1:0] addr);
        case (sel)
            LS_LH, LS_LHU, LS_SH: return addr[0];
            LS_LW, LS_SW:         return addr[1:0] != 2'b00;
            default:              return 1'b0;
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] ref_load(ls_sel_e sel, logic [DATA_W-1:0] addr);
        logic [RAM_DEPTH_LOG2+1:0] idx;
        logic [BYTE_W-1:0] b [4];
        for (int i = 0; i < 4; i++) begin
            idx  = addr[RAM_DEPTH_LOG2+1:0] + i;          // wraps like the RAM.
            b[i] = ref_mem[idx];
        end
        case (sel)
            LS_LB:   return {{24{b[0][7]}}, b[0]};
            LS_LBU:  return {24'h0, b[0]};
            LS_LH:   return {{16{b[1][7]}}, b[1], b[0]};
            LS_LHU:  return {16'h0, b[1], b[0]};
            LS_LW:   return {b[3], b[2], b[1], b[0]};
            default: return '0;
        endcase
    endfunction

    task automatic ref_store(input ls_sel_e sel, input logic [DATA_W-1:0] addr,
                             input logic [DATA_W-1:0] data);
        int n;
        logic [RAM_DEPTH_LOG2+1:0] idx;
        n = (sel == LS_SB) ? 1 : (sel == LS_SH) ? 2 : (sel == LS_SW) ? 4 : 0;
        for (int i = 0; i < n; i++) begin
            idx          = addr[RAM_DEPTH_LOG2+1:0] + i;
            ref_mem[idx] = data[i*BYTE_W +: BYTE_W];
        end
    endtask

    task automatic add_row(input ls_sel_e sel, input logic [DATA_W-1:0] addr,
                           input logic [DATA_W-1:0] rt, input wb_sel_e wbs, input logic ena,
                           input logic [REG_ADDR_W-1:0] dst, input int test);
        row_sel[n_rows]  = sel;
        row_addr[n_rows] = addr;
        row_rt[n_rows]   = rt;
        row_wbs[n_rows]  = wbs;
        row_ena[n_rows]  = ena;
        row_dst[n_rows]  = dst;
        row_test[n_rows] = test;
        rows_left[test]++;
        n_rows++;
    endtask

    task automatic add_store(input ls_sel_e sel, input logic [DATA_W-1:0] addr,
                             input logic [DATA_W-1:0] data, input int test);
        add_row(sel, addr, data, WB_ALU, 1'b0, '0, test);
    endtask

    task automatic add_load(input ls_sel_e sel, input logic [DATA_W-1:0] addr,
                            input logic [REG_ADDR_W-1:0] dst, input int test);
        add_row(sel, addr, '0, WB_MEM, 1'b1, dst, test);
    endtask

    task automatic build_table();
        logic [DATA_W-1:0] a [4];
        logic [DATA_W-1:0] base;
        for (int k = 0; k < 4; k++) begin
            a[k] = $urandom & 32'hffff_fffc;
            add_store(LS_SW, a[k], $urandom, 1);
            add_load(LS_LW, a[k], 5'(k + 1), 1);          // load right behind the store.
        end
        for (int k = 0; k < 4; k++) begin
            add_load(LS_LW, a[k], 5'(k + 8), 1);
        end
        add_store(LS_SW, 32'h0000_0200, $urandom, 2);
        for (int k = 0; k < 4; k++) begin
            add_store(LS_SB, 32'h0000_0200 + k, $urandom, 2);
            add_load(LS_LW, 32'h0000_0200, 5'd3, 2);
        end
        for (int k = 0; k < 4; k += 2) begin
            add_store(LS_SH, 32'h0000_0200 + k, $urandom, 2);
            add_load(LS_LW, 32'h0000_0200, 5'd4, 2);
        end
        add_store(LS_SW, 32'h0000_0300, 32'h8a7b_f512, 3);    // halves with the top bit set.
        add_store(LS_SW, 32'h0000_0304, 32'h7c35_49e6, 3);    // halves with the top bit clear.
        for (int j = 0; j < 2; j++) begin
            base = 32'h0000_0300 + 4 * j;
            for (int k = 0; k < 4; k++) begin
                add_load(LS_LB, base + k, 5'(k + 16), 3);
                add_load(LS_LBU, base + k, 5'(k + 20), 3);
            end
            for (int k = 0; k < 4; k += 2) begin
                add_load(LS_LH, base + k, 5'(k + 24), 3);
                add_load(LS_LHU, base + k, 5'(k + 25), 3);
            end
        end
        add_store(LS_SW, 32'h0000_0380, $urandom, 4);
        add_load(LS_LH, 32'h0000_0381, 5'd5, 4);
        add_load(LS_LHU, 32'h0000_0383, 5'd6, 4);
        add_load(LS_LH, 32'h0000_0382, 5'd7, 4);
        for (int k = 1; k < 4; k++) begin
            add_load(LS_LW, 32'h0000_0380 + k, 5'(k + 9), 4);
        end
        add_store(LS_SH, 32'h0000_0381, $urandom, 4);
        add_store(LS_SW, 32'h0000_0382, $urandom, 4);
        add_store(LS_SW, 32'h0000_0383, $urandom, 4);
        add_load(LS_LW, 32'h0000_0380, 5'd13, 4);         // memory must be unchanged.
        for (int k = 0; k < 6; k++) begin
            add_row(LS_NONE, $urandom, $urandom, WB_ALU, 1'($urandom), 5'($urandom), 5);
            add_load(LS_LW, 32'h0000_0200, 5'(k), 5);
        end
    endtask

    task automatic note_error();
        errors++;
        test_err[cur_test]++;
    endtask

    task automatic check_data(input logic [DATA_W-1:0] exp_val,
                              input logic [DATA_W-1:0] act_val);
        checks++;
        if (act_val !== exp_val) begin
            $display("ERR t=%0t wb_data exp=%08h act=%08h", $time, exp_val, act_val);
            note_error();
        end
    endtask

    task automatic check_exc(input exc_e exp_val, input exc_e act_val);
        checks++;
        if (act_val !== exp_val) begin
            $display("ERR t=%0t wb_exc exp=%s act=%s(%0b)", $time, exp_val.name(),
                     act_val.name(), act_val);
            note_error();
        end
    endtask

    task automatic check_ctrl(input logic exp_ena, input logic [REG_ADDR_W-1:0] exp_dst,
                              input logic exp_valid, input logic dst_known);
        checks++;
        if (wb_w_reg_ena !== exp_ena) begin
            $display("ERR t=%0t wb_w_reg_ena exp=%0b act=%0b", $time, exp_ena, wb_w_reg_ena);
            note_error();
        end
        if (dst_known && wb_w_reg_dst !== exp_dst) begin
            $display("ERR t=%0t wb_w_reg_dst exp=%0d act=%0d", $time, exp_dst, wb_w_reg_dst);
            note_error();
        end
        if (wb_valid !== exp_valid) begin
            $display("ERR t=%0t wb_valid exp=%0b act=%0b", $time, exp_valid, wb_valid);
            note_error();
        end
    endtask

    task automatic report_test(input int t);
        if (test_err[t] != 0) tests_failed++;
        $display("%-16s %0d errors, %s", test_name[t], test_err[t],
                 (test_err[t] == 0) ? "passed" : "failed");
    endtask

    task automatic drive_row(input int i);
        exp_t e;
        e.exc = misaligned(row_sel[i], row_addr[i]) ?
                ((row_sel[i] inside {LS_SB, LS_SH, LS_SW}) ? EXC_ADES : EXC_ADEL) : EXC_NONE;
        e.data = (row_wbs[i] == WB_MEM) ? ref_load(row_sel[i], row_addr[i]) : row_addr[i];
        e.chk_data = (e.exc == EXC_NONE);                 // faulting loads return stale data.
        e.ena = row_ena[i] & (e.exc == EXC_NONE);
        e.dst = row_dst[i];
        e.test = row_test[i];
        if (e.exc == EXC_NONE) ref_store(row_sel[i], row_addr[i], row_rt[i]);
        exp_q.push_back(e);
        ex_valid     = 1'b1;
        ex_ls_sel    = row_sel[i];
        ex_alu_res   = row_addr[i];
        ex_rt_data   = row_rt[i];
        ex_wb_sel    = row_wbs[i];
        ex_w_reg_ena = row_ena[i];
        ex_w_reg_dst = row_dst[i];
    endtask

    task automatic drive_idle();
        ex_valid     = 1'b0;
        ex_ls_sel    = LS_NONE;
        ex_alu_res   = '0;
        ex_rt_data   = '0;
        ex_wb_sel    = WB_ALU;
        ex_w_reg_ena = 1'b0;
        ex_w_reg_dst = '0;
    endtask

    task automatic check_head();
        exp_t e;
        e = exp_q.pop_front();
        cur_test = e.test;
        check_ctrl(e.ena, e.dst, 1'b1, 1'b1);
        check_exc(e.exc, wb_exc);
        if (e.chk_data) check_data(e.data, wb_data);
        rows_left[e.test]--;
        if (rows_left[e.test] == 0) report_test(e.test);
    endtask

    initial begin
        int row_idx;
        int cyc;
        int assert_fails;
        drive_idle();
        ex_valid     = 1'b1;                              // live instruction held in reset.
        ex_w_reg_ena = 1'b1;
        timed_out = 1'b0;
        void'($urandom(58455));
        build_table();
        for (int i = 0; i < 40 && rst_n !== 1'b1; i++) @(rst_n or negedge clk);
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end else begin
            cur_test = 0;
            check_ctrl(1'b0, '0, 1'b0, 1'b0);             // no clock edge since reset ended.
            check_exc(EXC_NONE, wb_exc);
            report_test(0);
            drive_idle();
            row_idx = 0;
            cyc = 0;
            while ((row_idx < n_rows || exp_q.size() > 0) && cyc < n_rows + 8) begin
                @(negedge clk);
                if (cyc >= 2 && exp_q.size() > 0) check_head();
                if (row_idx < n_rows) begin
                    drive_row(row_idx);
                    row_idx++;
                end else begin
                    drive_idle();
                end
                cyc++;
            end
            if (exp_q.size() != 0) begin
                $display("timeout: %0d results never reached write-back", exp_q.size());
                timed_out = 1'b1;
            end
            for (int i = 0; i < 8 && wb_valid === 1'b1; i++) @(negedge clk);
            if (wb_valid === 1'b1) begin
                $display("timeout: wb_valid stayed high after the last instruction");
                timed_out = 1'b1;
            end
        end
        assert_fails = mem_stage_top_inst.mem_stage_props_inst.fail_count;
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assert fails",
                 N_TESTS, tests_failed, checks, errors, assert_fails);
        if (errors == 0 && tests_failed == 0 && assert_fails == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* testbench/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 20;                     // 40 ns clock.
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;                                     // release away from the rising edge.
    end

endmodule
